// File: snn_weight_pkg.sv
// shared widths and types for the synaptic weight path
// the scaling code picks the left shift applied to a recalled weight

`default_nettype none

package snn_weight_pkg;

	// stored and scaled weight widths
	localparam int WEIGHT_W = 12;
	localparam int DATA_W = 16;

	// top address bits pick one of the banks
	localparam int BANK_SEL_W = 2;
	localparam int NUM_BANKS = 1 << BANK_SEL_W;

	// per-axon scaling code
	typedef enum logic [1:0] {
		SCALE_X1 = 2'b00,
		SCALE_X2 = 2'b01,
		SCALE_X4 = 2'b10,
		SCALE_X16 = 2'b11
	} scale_e;

	typedef logic [WEIGHT_W-1:0] weight_t;
	typedef logic [DATA_W-1:0] sweight_t;

	// shift amount for a scaling code, used on recall and on write-back
	function automatic int unsigned scale_shift(scale_e code);
		case (code)
			SCALE_X2: return 1;
			SCALE_X4: return 2;
			SCALE_X16: return 4;
			default: return 0;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: weight_bank.sv
// single bank of weight storage
// read address is captured on a read enable, data comes out of the array
// at the registered address

`default_nettype none
`timescale 1ns/1ps

module weight_bank #(
	parameter int ADDR_W = 10
) (
	input  logic                                      clk_i,
	input  logic                                      rd_en_i,
	input  logic [ADDR_W-snn_weight_pkg::BANK_SEL_W-1:0] rd_addr_i,
	input  logic                                      wr_en_i,
	input  logic [ADDR_W-snn_weight_pkg::BANK_SEL_W-1:0] wr_addr_i,
	input  snn_weight_pkg::weight_t                   wr_data_i,
	output snn_weight_pkg::weight_t                   rd_data_o
);
	import snn_weight_pkg::*;

	localparam int LOCAL_W = ADDR_W - BANK_SEL_W;
	localparam int DEPTH = 1 << LOCAL_W;

	weight_t mem [DEPTH];
	logic [LOCAL_W-1:0] rd_addr_q;

	always_ff @(posedge clk_i)
	begin
		if (rd_en_i)
		begin
			rd_addr_q <= rd_addr_i;
		end
		if (wr_en_i)
		begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// word at the last captured address
	assign rd_data_o = mem[rd_addr_q];

endmodule

`default_nettype wire

// File: recall_scaler.sv
// recall side of the weight path
// decodes the bank, picks the returning word one cycle later and applies
// the axon scaling, then pushes the result toward the weight FIFO

`default_nettype none
`timescale 1ns/1ps

module recall_scaler #(
	parameter int ADDR_W = 10
) (
	input  logic                                            clk_i,
	input  logic                                            rst_n_i,
	input  logic                                            recall_rd_en_i,
	input  logic [ADDR_W-1:0]                               recall_addr_i,
	input  snn_weight_pkg::scale_e                          recall_scale_i,
	output logic [snn_weight_pkg::NUM_BANKS-1:0]            bank_rd_en_o,
	output logic [ADDR_W-snn_weight_pkg::BANK_SEL_W-1:0]    bank_rd_addr_o,
	input  snn_weight_pkg::weight_t [snn_weight_pkg::NUM_BANKS-1:0] bank_rd_data_i,
	output snn_weight_pkg::sweight_t                        recall_data_o,
	output logic                                            push_en_o,
	output snn_weight_pkg::scale_e                          push_scale_o
);
	import snn_weight_pkg::*;

	localparam int LOCAL_W = ADDR_W - BANK_SEL_W;

	logic [BANK_SEL_W-1:0] rd_sel;
	logic [BANK_SEL_W-1:0] rd_sel_q;
	scale_e scale_q;
	weight_t sel_word;
	sweight_t ext_word;

	assign rd_sel = recall_addr_i[ADDR_W-1 -: BANK_SEL_W];
	assign bank_rd_addr_o = recall_addr_i[LOCAL_W-1:0];

	// only the addressed bank latches the read address
	always_comb
	begin
		bank_rd_en_o = '0;
		bank_rd_en_o[rd_sel] = recall_rd_en_i;
	end

	// bank select and scale follow the word through the bank read
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			rd_sel_q <= '0;
			scale_q <= SCALE_X1;
			push_en_o <= 1'b0;
		end
		else
		begin
			push_en_o <= recall_rd_en_i;
			if (recall_rd_en_i)
			begin
				rd_sel_q <= rd_sel;
				scale_q <= recall_scale_i;
			end
		end
	end

	assign sel_word = bank_rd_data_i[rd_sel_q];

	// sign-extend to the port width, then shift by the axon code
	assign ext_word = {{(DATA_W-WEIGHT_W){sel_word[WEIGHT_W-1]}}, sel_word};
	assign recall_data_o = ext_word << scale_shift(scale_q);
	assign push_scale_o = scale_q;

	// the bank decode must never open two banks at once
	a_one_bank_rd: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0(bank_rd_en_o)
	);

endmodule

`default_nettype wire

// File: weight_fifo.sv
// show-ahead FIFO holding scaled weights and their scaling codes
// head entry is always visible; each accepted pop also latches the head's
// scaling code for the learning write-back

`default_nettype none
`timescale 1ns/1ps

module weight_fifo #(
	parameter int FIFO_AW = 4
) (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     clear_i,
	input  logic                     push_en_i,
	input  snn_weight_pkg::sweight_t push_data_i,
	input  snn_weight_pkg::scale_e   push_scale_i,
	input  logic                     pop_i,
	output snn_weight_pkg::sweight_t head_data_o,
	output snn_weight_pkg::scale_e   head_scale_o,
	output snn_weight_pkg::scale_e   last_scale_o,
	output logic                     empty_o,
	output logic                     full_o
);
	import snn_weight_pkg::*;

	localparam int DEPTH = 1 << FIFO_AW;

	sweight_t data_mem [DEPTH];
	scale_e scale_mem [DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count;
	logic push_ok;
	logic pop_ok;

	assign empty_o = (count == '0);
	assign full_o = (count == (FIFO_AW+1)'(DEPTH));

	// a push into a full FIFO is lost, a pop from an empty one is ignored
	assign push_ok = push_en_i && !full_o;
	assign pop_ok = pop_i && !empty_o;

	always_ff @(posedge clk_i)
	begin
		if (push_ok)
		begin
			data_mem[wr_ptr] <= push_data_i;
			scale_mem[wr_ptr] <= push_scale_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			last_scale_o <= SCALE_X1;
		end
		else if (clear_i)
		begin
			// flush on start, last_scale keeps its value
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_ok)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok)
			begin
				rd_ptr <= rd_ptr + 1'b1;
				last_scale_o <= scale_mem[rd_ptr];
			end
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_data_o = data_mem[rd_ptr];
	assign head_scale_o = scale_mem[rd_ptr];

	// recall side has no back-pressure, so it must stop before the FIFO fills
	a_no_push_full: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!(push_en_i && full_o)
	);

endmodule

`default_nettype wire

// File: writeback_unscaler.sv
// write path into the weight banks
// config writes store the low bits as given, learning writes are scaled
// back by the code of the last popped FIFO entry

`default_nettype none
`timescale 1ns/1ps

module writeback_unscaler #(
	parameter int ADDR_W = 10
) (
	input  logic                                         wr_en_i,
	input  logic [ADDR_W-1:0]                            wr_addr_i,
	input  snn_weight_pkg::sweight_t                     wr_data_i,
	input  logic                                         cfg_mode_i,
	input  snn_weight_pkg::scale_e                       last_scale_i,
	output logic [snn_weight_pkg::NUM_BANKS-1:0]         bank_wr_en_o,
	output logic [ADDR_W-snn_weight_pkg::BANK_SEL_W-1:0] bank_wr_addr_o,
	output snn_weight_pkg::weight_t                      bank_wr_data_o
);
	import snn_weight_pkg::*;

	localparam int LOCAL_W = ADDR_W - BANK_SEL_W;

	logic [BANK_SEL_W-1:0] wr_sel;
	sweight_t unscaled;

	assign wr_sel = wr_addr_i[ADDR_W-1 -: BANK_SEL_W];
	assign bank_wr_addr_o = wr_addr_i[LOCAL_W-1:0];

	always_comb
	begin
		bank_wr_en_o = '0;
		bank_wr_en_o[wr_sel] = wr_en_i;
	end

	// x1 takes 11..0, x2 12..1, x4 13..2, x16 15..4
	assign unscaled = wr_data_i >> scale_shift(last_scale_i);

	assign bank_wr_data_o = cfg_mode_i ? wr_data_i[WEIGHT_W-1:0] : unscaled[WEIGHT_W-1:0];

	// write data must be known on every write
	always_comb
	begin
		if (wr_en_i)
		begin
			a_wr_data_known: assert final (!$isunknown(wr_data_i));
		end
	end

endmodule

`default_nettype wire

// File: snn_weight_top.sv
// synaptic weight path of the neuron core
// four weight banks with a recall scaler, a weight FIFO toward the
// learning stage and a write-back unscaler

`default_nettype none
`timescale 1ns/1ps

module snn_weight_top #(
	parameter int ADDR_W = 10,
	parameter int FIFO_AW = 4
) (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     start_i,
	input  logic                     recall_rd_en_i,
	input  logic [ADDR_W-1:0]        recall_addr_i,
	input  snn_weight_pkg::scale_e   recall_scale_i,
	input  logic                     learn_rd_en_i,
	input  logic                     wr_en_i,
	input  logic [ADDR_W-1:0]        wr_addr_i,
	input  snn_weight_pkg::sweight_t wr_data_i,
	input  logic                     cfg_mode_i,
	output snn_weight_pkg::sweight_t recall_data_o,
	output snn_weight_pkg::sweight_t learn_data_o,
	output snn_weight_pkg::scale_e   learn_scale_o,
	output logic                     fifo_empty_o,
	output logic                     fifo_full_o
);
	import snn_weight_pkg::*;

	localparam int LOCAL_W = ADDR_W - BANK_SEL_W;

	logic [NUM_BANKS-1:0] bank_rd_en;
	logic [NUM_BANKS-1:0] bank_wr_en;
	logic [LOCAL_W-1:0] bank_rd_addr;
	logic [LOCAL_W-1:0] bank_wr_addr;
	weight_t [NUM_BANKS-1:0] bank_rd_data;
	weight_t bank_wr_data;
	logic push_en;
	scale_e push_scale;
	scale_e last_scale;

	for (genvar b = 0; b < NUM_BANKS; b++)
	begin : g_bank
		weight_bank #(
			.ADDR_W(ADDR_W)
		) u_bank (
			.clk_i    (clk_i),
			.rd_en_i  (bank_rd_en[b]),
			.rd_addr_i(bank_rd_addr),
			.wr_en_i  (bank_wr_en[b]),
			.wr_addr_i(bank_wr_addr),
			.wr_data_i(bank_wr_data),
			.rd_data_o(bank_rd_data[b])
		);
	end

	recall_scaler #(
		.ADDR_W(ADDR_W)
	) u_recall_scaler (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.recall_rd_en_i(recall_rd_en_i),
		.recall_addr_i (recall_addr_i),
		.recall_scale_i(recall_scale_i),
		.bank_rd_en_o  (bank_rd_en),
		.bank_rd_addr_o(bank_rd_addr),
		.bank_rd_data_i(bank_rd_data),
		.recall_data_o (recall_data_o),
		.push_en_o     (push_en),
		.push_scale_o  (push_scale)
	);

	// recalled weight goes straight into the FIFO
	weight_fifo #(
		.FIFO_AW(FIFO_AW)
	) u_weight_fifo (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.clear_i     (start_i),
		.push_en_i   (push_en),
		.push_data_i (recall_data_o),
		.push_scale_i(push_scale),
		.pop_i       (learn_rd_en_i),
		.head_data_o (learn_data_o),
		.head_scale_o(learn_scale_o),
		.last_scale_o(last_scale),
		.empty_o     (fifo_empty_o),
		.full_o      (fifo_full_o)
	);

	writeback_unscaler #(
		.ADDR_W(ADDR_W)
	) u_writeback_unscaler (
		.wr_en_i       (wr_en_i),
		.wr_addr_i     (wr_addr_i),
		.wr_data_i     (wr_data_i),
		.cfg_mode_i    (cfg_mode_i),
		.last_scale_i  (last_scale),
		.bank_wr_en_o  (bank_wr_en),
		.bank_wr_addr_o(bank_wr_addr),
		.bank_wr_data_o(bank_wr_data)
	);

endmodule

`default_nettype wire

// File: tb_clkgen.sv
// clock and reset source for the weight path testbench
// 10 ns clock, reset held low for the first 10 cycles

`default_nettype none
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	initial
	begin
		rst_n_o = 1'b0;
		repeat (10) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: tb_checker.sv
// output monitor for the weight path testbench
// compares DUT outputs with the model's expectations in the middle of
// each cycle, once they have settled

`default_nettype none
`timescale 1ns/1ps

module tb_checker (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     check_en_i,
	input  snn_weight_pkg::sweight_t recall_data_i,
	input  snn_weight_pkg::sweight_t learn_data_i,
	input  snn_weight_pkg::scale_e   learn_scale_i,
	input  logic                     fifo_empty_i,
	input  logic                     fifo_full_i,
	input  logic                     exp_recall_valid_i,
	input  snn_weight_pkg::sweight_t exp_recall_data_i,
	input  snn_weight_pkg::sweight_t exp_learn_data_i,
	input  snn_weight_pkg::scale_e   exp_learn_scale_i,
	input  logic                     exp_empty_i,
	input  logic                     exp_full_i,
	output int                       err_count_o,
	output int                       check_count_o
);

	int errs = 0;
	int checks = 0;

	assign err_count_o = errs;
	assign check_count_o = checks;

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp)
		begin
			errs++;
			$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	always @(negedge clk_i)
	begin
		if (rst_n_i && check_en_i)
		begin
			compare("fifo_empty_o", 16'(fifo_empty_i), 16'(exp_empty_i));
			compare("fifo_full_o", 16'(fifo_full_i), 16'(exp_full_i));
			// head is only meaningful while the FIFO holds something
			if (!exp_empty_i)
			begin
				compare("learn_data_o", learn_data_i, exp_learn_data_i);
				compare("learn_scale_o", 16'(learn_scale_i), 16'(exp_learn_scale_i));
			end
			if (exp_recall_valid_i)
			begin
				compare("recall_data_o", recall_data_i, exp_recall_data_i);
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_top.sv
// testbench top for the synaptic weight path
// random config, recall, pop and learning traffic against a small model

`default_nettype none
`timescale 1ns/1ps

module tb_top;
	import snn_weight_pkg::*;

	localparam int ADDR_W = 10;
	localparam int FIFO_AW = 4;
	localparam int DEPTH = 1 << FIFO_AW;

	logic clk;
	logic rst_n;
	logic start;
	logic recall_en;
	logic [ADDR_W-1:0] recall_addr;
	scale_e recall_scale;
	logic learn_en;
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	sweight_t wr_data;
	logic cfg;
	sweight_t recall_data;
	sweight_t learn_data;
	scale_e learn_scale;
	logic fifo_empty;
	logic fifo_full;

	// expectations handed to the checker
	logic check_en;
	logic exp_recall_valid;
	sweight_t exp_recall_data;
	sweight_t exp_learn_data;
	scale_e exp_learn_scale;
	logic exp_empty;
	logic exp_full;
	int chk_errs;
	int chk_count;
	int other_errs;

	// reference model
	weight_t model_mem [1 << ADDR_W];
	sweight_t q_data [$];
	scale_e q_scale [$];
	scale_e model_last_scale;
	logic pend_push;
	sweight_t pend_data;
	scale_e pend_scale;

	tb_clkgen u_clkgen (
		.clk_o  (clk),
		.rst_n_o(rst_n)
	);

	snn_weight_top #(
		.ADDR_W (ADDR_W),
		.FIFO_AW(FIFO_AW)
	) dut_i (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.start_i       (start),
		.recall_rd_en_i(recall_en),
		.recall_addr_i (recall_addr),
		.recall_scale_i(recall_scale),
		.learn_rd_en_i (learn_en),
		.wr_en_i       (wr_en),
		.wr_addr_i     (wr_addr),
		.wr_data_i     (wr_data),
		.cfg_mode_i    (cfg),
		.recall_data_o (recall_data),
		.learn_data_o  (learn_data),
		.learn_scale_o (learn_scale),
		.fifo_empty_o  (fifo_empty),
		.fifo_full_o   (fifo_full)
	);

	tb_checker u_checker (
		.clk_i             (clk),
		.rst_n_i           (rst_n),
		.check_en_i        (check_en),
		.recall_data_i     (recall_data),
		.learn_data_i      (learn_data),
		.learn_scale_i     (learn_scale),
		.fifo_empty_i      (fifo_empty),
		.fifo_full_i       (fifo_full),
		.exp_recall_valid_i(exp_recall_valid),
		.exp_recall_data_i (exp_recall_data),
		.exp_learn_data_i  (exp_learn_data),
		.exp_learn_scale_i (exp_learn_scale),
		.exp_empty_i       (exp_empty),
		.exp_full_i        (exp_full),
		.err_count_o       (chk_errs),
		.check_count_o     (chk_count)
	);

	// sign-extend, then multiply by the axon factor
	function automatic sweight_t scaled_weight(input weight_t w, input scale_e s);
		sweight_t ext;
		ext = {{4{w[11]}}, w};
		case (s)
			SCALE_X2: return ext << 1;
			SCALE_X4: return ext << 2;
			SCALE_X16: return ext << 4;
			default: return ext;
		endcase
	endfunction

	// bit field kept by a learning write-back
	function automatic weight_t field_for_scale(input sweight_t d, input scale_e s);
		case (s)
			SCALE_X2: return d[12:1];
			SCALE_X4: return d[13:2];
			SCALE_X16: return d[15:4];
			default: return d[11:0];
		endcase
	endfunction

	function automatic logic fifo_state_ok(input int kind);
		case (kind)
			0: return fifo_empty;
			1: return !fifo_empty;
			default: return fifo_full;
		endcase
	endfunction

	task automatic set_idle();
		start = 1'b0;
		recall_en = 1'b0;
		learn_en = 1'b0;
		wr_en = 1'b0;
		cfg = 1'b0;
	endtask

	// apply the inputs sampled at the edge just passed to the model
	task automatic commit_model();
		logic push_now;
		logic was_full;
		sweight_t push_val;
		scale_e push_scl;
		push_now = pend_push;
		push_val = pend_data;
		push_scl = pend_scale;
		// the write uses the code popped before this edge
		if (wr_en)
		begin
			model_mem[wr_addr] = cfg ? wr_data[11:0] : field_for_scale(wr_data, model_last_scale);
		end
		pend_push = recall_en;
		if (recall_en)
		begin
			pend_data = scaled_weight(model_mem[recall_addr], recall_scale);
			pend_scale = recall_scale;
		end
		exp_recall_valid = recall_en;
		exp_recall_data = pend_data;
		if (start)
		begin
			q_data.delete();
			q_scale.delete();
		end
		else
		begin
			was_full = (q_data.size() == DEPTH);
			if (learn_en && q_data.size() > 0)
			begin
				model_last_scale = q_scale.pop_front();
				q_data.delete(0);
			end
			if (push_now && !was_full)
			begin
				q_data.push_back(push_val);
				q_scale.push_back(push_scl);
			end
		end
		exp_empty = (q_data.size() == 0);
		exp_full = (q_data.size() == DEPTH);
		if (q_data.size() > 0)
		begin
			exp_learn_data = q_data[0];
			exp_learn_scale = q_scale[0];
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#1;
		commit_model();
	endtask

	task automatic config_write(input logic [ADDR_W-1:0] a, input sweight_t d);
		wr_en = 1'b1;
		cfg = 1'b1;
		wr_addr = a;
		wr_data = d;
		tick();
		set_idle();
	endtask

	task automatic learn_write(input logic [ADDR_W-1:0] a, input sweight_t d);
		wr_en = 1'b1;
		wr_addr = a;
		wr_data = d;
		tick();
		set_idle();
	endtask

	task automatic recall(input logic [ADDR_W-1:0] a, input scale_e s);
		recall_en = 1'b1;
		recall_addr = a;
		recall_scale = s;
		tick();
		set_idle();
	endtask

	task automatic wait_fifo(input int kind, input string what);
		int n;
		n = 0;
		while (!fifo_state_ok(kind) && n < 64)
		begin
			tick();
			n++;
		end
		if (!fifo_state_ok(kind))
		begin
			$display("timeout while waiting for the FIFO to become %s", what);
			other_errs++;
		end
	endtask

	// one edge first so a push still in flight lands, then pop until empty
	task automatic drain();
		learn_en = 1'b1;
		tick();
		wait_fifo(0, "empty");
		set_idle();
	endtask

	initial
	begin
		int n;
		logic [ADDR_W-1:0] a;
		logic [ADDR_W-3:0] la;
		weight_t base;
		void'($urandom(32'hd51f));
		set_idle();
		recall_addr = '0;
		recall_scale = SCALE_X1;
		wr_addr = '0;
		wr_data = '0;
		check_en = 1'b0;
		exp_recall_valid = 1'b0;
		exp_recall_data = '0;
		exp_learn_data = '0;
		exp_learn_scale = SCALE_X1;
		exp_empty = 1'b1;
		exp_full = 1'b0;
		other_errs = 0;
		model_last_scale = SCALE_X1;
		pend_push = 1'b0;
		pend_data = '0;
		pend_scale = SCALE_X1;

		n = 0;
		while (!rst_n && n < 50)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!rst_n)
		begin
			$display("timeout while waiting for reset release");
			other_errs++;
		end
		else
		begin
			check_en = 1'b1;
			// every word gets a known value first
			for (int i = 0; i < (1 << ADDR_W); i++)
				config_write(ADDR_W'(i), sweight_t'($urandom));
			for (int i = 0; i < 64; i++)
				config_write(ADDR_W'($urandom), sweight_t'($urandom));

			// recalls at all four scales, random pops, FIFO kept below full
			for (int i = 0; i < 200; i++)
			begin
				learn_en = 1'($urandom_range(1, 0));
				if (q_data.size() + 2 < DEPTH && $urandom_range(3, 0) != 0)
				begin
					recall_en = 1'b1;
					recall_addr = ADDR_W'($urandom);
					recall_scale = scale_e'(i % 4);
				end
				tick();
				set_idle();
			end
			drain();

			// same local address in each bank holds its own value
			for (int r = 0; r < 8; r++)
			begin
				la = (ADDR_W-2)'($urandom);
				base = weight_t'($urandom);
				for (int b = 0; b < NUM_BANKS; b++)
					config_write({b[1:0], la}, {4'h0, base ^ weight_t'(b * 12'h111)});
				for (int b = 0; b < NUM_BANKS; b++)
					recall({b[1:0], la}, SCALE_X1);
				drain();
			end

			// learning write-back with the popped entry's scale
			for (int r = 0; r < 24; r++)
			begin
				recall(ADDR_W'($urandom), scale_e'($urandom_range(3, 0)));
				wait_fifo(1, "non-empty");
				learn_en = 1'b1;
				tick();
				set_idle();
				a = ADDR_W'($urandom);
				learn_write(a, sweight_t'($urandom));
				recall(a, SCALE_X1);
				drain();
			end

			// fill without pops, then flush
			for (int i = 0; i < DEPTH; i++)
				recall(ADDR_W'($urandom), scale_e'($urandom_range(3, 0)));
			wait_fifo(2, "full");
			start = 1'b1;
			tick();
			set_idle();
			wait_fifo(0, "empty after flush");
		end

		@(negedge clk);
		#1;
		$display("checks %0d, compare errors %0d, other failures %0d",
			chk_count, chk_errs, other_errs);
		if (chk_errs == 0 && other_errs == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
snn_weight_pkg.sv
weight_bank.sv
recall_scaler.sv
weight_fifo.sv
writeback_unscaler.sv
snn_weight_top.sv
tb_clkgen.sv
tb_checker.sv
tb_top.sv

// File: Makefile
# Verilator build for the synaptic weight path

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_top -f flist.f

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_top -f flist.f -o tb_sim
	out="$$(./obj_dir/tb_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
